// File: Makefile
VERILATOR ?= verilator
TOP       ?= processing_unit_tb
RTL_TOP   ?= processing_unit
FILELIST  ?= processing_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SOURCES   := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: design/cluster_state.sv
`timescale 1ns/1ns
`default_nettype none
`include "decoder_settings.svh"

module cluster_state #(
    parameter int unsigned k = 0,
    parameter int unsigned i = 0,
    parameter int unsigned j = 0
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire stage_pkg::stage_t           stage_in,
    input  wire                              init_is_error_syndrome,
    input  wire message_pkg::neighbor_mask_t neighbor_is_fully_grown,
    input  wire message_pkg::address_t       neighbor_roots [`NEIGHBOR_COUNT],
    input  wire message_pkg::neighbor_mask_t neighbor_is_odd_cluster,
    input  wire                              gathered_odd,       // from consumed messages
    input  wire                              gathered_touching,
    output stage_pkg::stage_t                stage,
    output stage_pkg::stage_t                stage_delayed,
    output message_pkg::address_t            address,
    output message_pkg::address_t            new_root,
    output logic                             tell_cardinality,
    output logic                             tell_boundary,
    output logic                             neighbor_increase,
    output logic                             state_busy,
    output message_pkg::address_t            old_root,
    output message_pkg::address_t            updated_root,
    output logic                             is_error_syndrome,
    output logic                             is_odd_cluster,
    output logic                             is_touching_boundary,
    output logic                             is_odd_cardinality
);

    localparam message_pkg::address_t own_address = {
        message_pkg::coord_t'(k), message_pkg::coord_t'(i), message_pkg::coord_t'(j)
    };
    localparam bit has_boundary_z = (j == 0) || (j == `CODE_DISTANCE_Z - 1);  // edge rows
    localparam bit has_boundary_ud = (k == 0);  // first round only
    localparam message_pkg::boundary_cnt_t cost_z = `BOUNDARY_COST_Z;
    localparam message_pkg::boundary_cnt_t cost_ud = `BOUNDARY_COST_UD;

    message_pkg::boundary_cnt_t grown_z;   // steps grown toward z edge
    message_pkg::boundary_cnt_t grown_ud;
    logic root_changed;
    logic reached_boundary;
    logic updated_touching;
    logic updated_odd_cardinality;
    logic is_root_odd;          // root of an odd, free cluster
    logic merged_odd_cluster;
    logic first_sync;
    logic first_grow;
    logic broadcast_odd;
    logic changed;
    logic changed_q;            // stretches busy by a cycle

    assign address = own_address;

    root_compare_tree u_root_compare_tree (
        .default_root (updated_root),
        .roots        (neighbor_roots),
        .valids       (neighbor_is_fully_grown),
        .result       (new_root)
    );

    assign root_changed = new_root != updated_root;
    assign reached_boundary = (has_boundary_z && grown_z == cost_z)
        || (has_boundary_ud && grown_ud == cost_ud);
    assign updated_touching = is_touching_boundary || reached_boundary || gathered_touching;
    assign updated_odd_cardinality = is_odd_cardinality ^ gathered_odd;

    // what the new root has to learn from this site
    assign tell_cardinality = root_changed && is_error_syndrome;
    assign tell_boundary = (root_changed && updated_touching)
        || (updated_touching != is_touching_boundary);

    assign is_root_odd = (updated_root == address) && is_odd_cardinality && !is_touching_boundary;
    assign merged_odd_cluster = is_odd_cluster || (|neighbor_is_odd_cluster);
    assign first_sync = (stage == stage_pkg::STAGE_SYNC_IS_ODD_CLUSTER)
        && (stage_delayed != stage_pkg::STAGE_SYNC_IS_ODD_CLUSTER);
    assign first_grow = (stage == stage_pkg::STAGE_GROW_BOUNDARY)
        && (stage_delayed != stage_pkg::STAGE_GROW_BOUNDARY);
    assign neighbor_increase = is_odd_cluster && first_grow;  // one pulse per grow stage

    assign broadcast_odd = (stage == stage_pkg::STAGE_SYNC_IS_ODD_CLUSTER)
        && (first_sync ? is_root_odd : (merged_odd_cluster != is_odd_cluster));
    assign changed = ((stage == stage_pkg::STAGE_SPREAD_CLUSTER) && root_changed) || broadcast_odd;
    assign state_busy = changed || changed_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= stage_pkg::STAGE_IDLE;
            stage_delayed <= stage_pkg::STAGE_IDLE;
            changed_q <= 1'b0;
        end else begin
            stage <= stage_in;
            stage_delayed <= stage;
            changed_q <= changed;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            old_root <= own_address;
            updated_root <= own_address;
            is_error_syndrome <= 1'b0;
            is_odd_cluster <= 1'b0;
            is_touching_boundary <= 1'b0;
            is_odd_cardinality <= 1'b0;
            grown_z <= '0;
            grown_ud <= '0;
        end else begin
            case (stage)
                stage_pkg::STAGE_SPREAD_CLUSTER: begin
                    updated_root <= new_root;
                    is_touching_boundary <= updated_touching;
                    is_odd_cardinality <= updated_odd_cardinality;
                    is_odd_cluster <= 1'b0;
                end
                stage_pkg::STAGE_GROW_BOUNDARY: begin
                    if (neighbor_increase) begin  // odd cluster grows once
                        if (has_boundary_z && grown_z < cost_z) begin
                            grown_z <= grown_z + message_pkg::boundary_cnt_t'(1);
                        end
                        if (has_boundary_ud && grown_ud < cost_ud) begin
                            grown_ud <= grown_ud + message_pkg::boundary_cnt_t'(1);
                        end
                    end
                end
                stage_pkg::STAGE_SYNC_IS_ODD_CLUSTER: begin
                    if (first_sync) begin
                        is_odd_cluster <= is_root_odd;  // roots seed the flag
                        old_root <= updated_root;
                    end else begin
                        is_odd_cluster <= merged_odd_cluster;  // spreads hop by hop
                    end
                end
                stage_pkg::STAGE_MEASUREMENT_LOADING: begin
                    old_root <= own_address;
                    updated_root <= own_address;
                    is_error_syndrome <= init_is_error_syndrome;
                    is_odd_cluster <= init_is_error_syndrome;  // lone defect is odd
                    is_touching_boundary <= 1'b0;
                    is_odd_cardinality <= init_is_error_syndrome;
                    grown_z <= '0;
                    grown_ud <= '0;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// lattice geometry
`define PER_DIM_WIDTH 5           // bits per coordinate
`define CODE_DISTANCE_Z 26        // sites along j

// link counts per unit
`define NEIGHBOR_COUNT 6
`define DIRECT_CHANNEL_COUNT 3    // one per dimension

// boundary growth
`define BOUNDARY_WIDTH 2
`define BOUNDARY_COST_Z 2         // grow steps until the z edge is reached
`define BOUNDARY_COST_UD 2

`endif

// File: design/direct_message_router.sv
`timescale 1ns/1ns
`default_nettype none
`include "decoder_settings.svh"

module direct_message_router (
    input  wire                            clk,
    input  wire                            reset,
    input  wire stage_pkg::stage_t         stage,
    input  wire stage_pkg::stage_t         stage_delayed,
    input  wire message_pkg::address_t     address,
    input  wire message_pkg::address_t     new_root,
    input  wire                            tell_cardinality,
    input  wire                            tell_boundary,
    input  wire message_pkg::direct_msg_t  direct_in_data [`DIRECT_CHANNEL_COUNT],
    input  wire message_pkg::direct_mask_t direct_in_valid,
    input  wire message_pkg::direct_mask_t direct_out_is_full,
    output logic                           gathered_odd,
    output logic                           gathered_touching,
    output message_pkg::direct_mask_t      direct_in_is_taken,
    output message_pkg::direct_msg_t       direct_out_data,
    output message_pkg::direct_mask_t      direct_out_valid,
    output logic                           router_busy
);

    message_pkg::direct_mask_t matched;     // receiver is this site
    message_pkg::direct_mask_t odd_bits;
    message_pkg::direct_mask_t touch_bits;
    message_pkg::direct_mask_t local_hit;
    message_pkg::direct_mask_t foreign;
    message_pkg::direct_mask_t fwd_grant;   // lowest foreign channel
    message_pkg::direct_mask_t chosen;      // outgoing channel, one-hot
    message_pkg::direct_msg_t fwd_data;
    message_pkg::direct_msg_t own_msg;
    message_pkg::direct_msg_t buf_in;
    message_pkg::direct_msg_t buf_data;
    logic in_spread;
    logic fwd_valid;
    logic own_valid;
    logic own_trigger;
    logic buf_full;
    logic buf_valid;
    logic buf_taken;
    logic initialize;

    assign in_spread = stage == stage_pkg::STAGE_SPREAD_CLUSTER;
    assign initialize = stage == stage_pkg::STAGE_MEASUREMENT_LOADING;

    always_comb begin
        for (int c = 0; c < `DIRECT_CHANNEL_COUNT; c++) begin
            matched[c] = direct_in_data[c].receiver == address;
            odd_bits[c] = direct_in_data[c].is_odd_cardinality;
            touch_bits[c] = direct_in_data[c].is_touching_boundary;
        end
    end

    assign local_hit = direct_in_valid & matched;
    assign gathered_odd = ^(local_hit & odd_bits);       // parity of joined defects
    assign gathered_touching = |(local_hit & touch_bits);

    assign foreign = in_spread ? (direct_in_valid & ~matched) : '0;
    assign fwd_grant = foreign & (~foreign + message_pkg::direct_mask_t'(1));
    assign fwd_valid = |foreign;

    always_comb begin
        fwd_data = '0;
        for (int c = 0; c < `DIRECT_CHANNEL_COUNT; c++) begin
            if (fwd_grant[c]) begin
                fwd_data = direct_in_data[c];
            end
        end
    end

    // local ones always, foreign one only when the buffer accepts it
    assign direct_in_is_taken = in_spread ? (local_hit | (buf_full ? '0 : fwd_grant)) : '0;

    // a root already holds its own flags
    assign own_trigger = in_spread && (tell_cardinality || tell_boundary) && (new_root != address);

    always_ff @(posedge clk) begin
        if (own_trigger) begin
            own_msg <= {new_root, tell_cardinality, tell_boundary};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            own_valid <= 1'b0;
        end else if (initialize) begin
            own_valid <= 1'b0;
        end else if (own_trigger) begin
            own_valid <= 1'b1;
        end else if (!fwd_valid && !buf_full) begin
            own_valid <= 1'b0;  // moved into the buffer
        end
    end

    assign buf_in = fwd_valid ? fwd_data : own_msg;  // traffic in flight goes first

    message_buffer u_message_buffer (
        .clk          (clk),
        .reset        (reset),
        .initialize   (initialize),
        .in_data      (buf_in),
        .in_valid     (fwd_valid || own_valid),
        .in_is_full   (buf_full),
        .out_data     (buf_data),
        .out_valid    (buf_valid),
        .out_is_taken (buf_taken)
    );

    // dimension order, k first then i then j
    always_comb begin
        if (buf_data.receiver.k != address.k) begin
            chosen = message_pkg::direct_mask_t'(1);
        end else if (buf_data.receiver.i != address.i) begin
            chosen = message_pkg::direct_mask_t'(2);
        end else begin
            chosen = message_pkg::direct_mask_t'(4);
        end
    end

    assign direct_out_data = buf_data;
    assign direct_out_valid = ((stage_delayed == stage_pkg::STAGE_SPREAD_CLUSTER) && buf_valid
        && (buf_data.receiver != address)) ? chosen : '0;
    assign buf_taken = |(direct_out_valid & ~direct_out_is_full);

    assign router_busy = (|direct_out_valid) || (|direct_in_valid) || buf_valid || own_valid;

endmodule

`default_nettype wire

// File: design/message_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module message_buffer (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           initialize,   // drop whatever is held
    input  wire message_pkg::direct_msg_t in_data,
    input  wire                           in_valid,
    output logic                          in_is_full,
    output message_pkg::direct_msg_t      out_data,
    output logic                          out_valid,
    input  wire                           out_is_taken
);

    // full unless empty or draining this cycle
    assign in_is_full = out_valid && !out_is_taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (initialize) begin
            out_valid <= 1'b0;
        end else if (!in_is_full) begin
            out_valid <= in_valid;  // refill or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !in_is_full) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: design/message_pkg.sv
`default_nettype none
`include "decoder_settings.svh"

package message_pkg;

    typedef logic [`PER_DIM_WIDTH-1:0] coord_t;

    // k on top so the packed value orders sites
    typedef struct packed {
        coord_t k;  // measurement round
        coord_t i;
        coord_t j;
    } address_t;

    // tells a new root what joined its cluster
    typedef struct packed {
        address_t receiver;
        logic     is_odd_cardinality;
        logic     is_touching_boundary;
    } direct_msg_t;

    typedef logic [`BOUNDARY_WIDTH-1:0] boundary_cnt_t;
    typedef logic [`DIRECT_CHANNEL_COUNT-1:0] direct_mask_t;
    typedef logic [`NEIGHBOR_COUNT-1:0] neighbor_mask_t;

endpackage

`default_nettype wire

// File: design/processing_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "decoder_settings.svh"

module processing_unit #(
    parameter int unsigned k = 0,
    parameter int unsigned i = 0,
    parameter int unsigned j = 0
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              init_is_error_syndrome,
    input  wire stage_pkg::stage_t           stage_in,
    input  wire message_pkg::neighbor_mask_t neighbor_is_fully_grown,
    input  wire message_pkg::neighbor_mask_t neighbor_is_odd_cluster,
    input  wire message_pkg::address_t       neighbor_roots [`NEIGHBOR_COUNT],
    output logic                             neighbor_increase,
    output message_pkg::direct_msg_t         direct_out_data,
    output message_pkg::direct_mask_t        direct_out_valid,
    input  wire message_pkg::direct_mask_t   direct_out_is_full,
    input  wire message_pkg::direct_msg_t    direct_in_data [`DIRECT_CHANNEL_COUNT],
    input  wire message_pkg::direct_mask_t   direct_in_valid,
    output message_pkg::direct_mask_t        direct_in_is_taken,
    output message_pkg::address_t            old_root,
    output message_pkg::address_t            updated_root,
    output logic                             is_error_syndrome,
    output logic                             is_odd_cluster,
    output logic                             is_touching_boundary,
    output logic                             is_odd_cardinality,
    output logic                             is_processing
);

    stage_pkg::stage_t stage;
    stage_pkg::stage_t stage_delayed;
    message_pkg::address_t address;
    message_pkg::address_t new_root;
    logic tell_cardinality;
    logic tell_boundary;
    logic gathered_odd;
    logic gathered_touching;
    logic state_busy;
    logic router_busy;

    cluster_state #(.k(k), .i(i), .j(j)) u_cluster_state (
        .clk                     (clk),
        .reset                   (reset),
        .stage_in                (stage_in),
        .init_is_error_syndrome  (init_is_error_syndrome),
        .neighbor_is_fully_grown (neighbor_is_fully_grown),
        .neighbor_roots          (neighbor_roots),
        .neighbor_is_odd_cluster (neighbor_is_odd_cluster),
        .gathered_odd            (gathered_odd),
        .gathered_touching       (gathered_touching),
        .stage                   (stage),
        .stage_delayed           (stage_delayed),
        .address                 (address),
        .new_root                (new_root),
        .tell_cardinality        (tell_cardinality),
        .tell_boundary           (tell_boundary),
        .neighbor_increase       (neighbor_increase),
        .state_busy              (state_busy),
        .old_root                (old_root),
        .updated_root            (updated_root),
        .is_error_syndrome       (is_error_syndrome),
        .is_odd_cluster          (is_odd_cluster),
        .is_touching_boundary    (is_touching_boundary),
        .is_odd_cardinality      (is_odd_cardinality)
    );

    direct_message_router u_direct_message_router (
        .clk                (clk),
        .reset              (reset),
        .stage              (stage),
        .stage_delayed      (stage_delayed),
        .address            (address),
        .new_root           (new_root),
        .tell_cardinality   (tell_cardinality),
        .tell_boundary      (tell_boundary),
        .direct_in_data     (direct_in_data),
        .direct_in_valid    (direct_in_valid),
        .direct_out_is_full (direct_out_is_full),
        .gathered_odd       (gathered_odd),
        .gathered_touching  (gathered_touching),
        .direct_in_is_taken (direct_in_is_taken),
        .direct_out_data    (direct_out_data),
        .direct_out_valid   (direct_out_valid),
        .router_busy        (router_busy)
    );

    assign is_processing = state_busy || router_busy;  // array waits until all units idle

endmodule

`default_nettype wire

// File: design/root_compare_tree.sv
`timescale 1ns/1ns
`default_nettype none
`include "decoder_settings.svh"

module root_compare_tree (
    input  wire message_pkg::address_t       default_root,
    input  wire message_pkg::address_t       roots [`NEIGHBOR_COUNT],
    input  wire message_pkg::neighbor_mask_t valids,
    output message_pkg::address_t            result
);

    localparam int LEAVES = 1 << $clog2(`NEIGHBOR_COUNT);  // padded to a power of two

    // heap layout, leaves first, root at the last index
    message_pkg::address_t node [2*LEAVES-1];

    for (genvar n = 0; n < LEAVES; n++) begin : g_leaf
        if (n < `NEIGHBOR_COUNT) begin : g_used
            assign node[n] = valids[n] ? roots[n] : default_root;  // invalid falls back
        end else begin : g_pad
            assign node[n] = default_root;
        end
    end

    for (genvar n = 0; n < LEAVES - 1; n++) begin : g_min
        assign node[LEAVES+n] = (node[2*n] < node[2*n+1]) ? node[2*n] : node[2*n+1];
    end

    assign result = node[2*LEAVES-2];

endmodule

`default_nettype wire

// File: design/stage_pkg.sv
`default_nettype none

package stage_pkg;

    // global phase, broadcast to every unit of the array
    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_SPREAD_CLUSTER      = 3'd1,  // roots propagate, direct messages flow
        STAGE_GROW_BOUNDARY       = 3'd2,
        STAGE_SYNC_IS_ODD_CLUSTER = 3'd3,
        STAGE_MEASUREMENT_LOADING = 3'd4   // new syndrome round
    } stage_t;

endpackage

`default_nettype wire

// File: processing_unit.f
+incdir+design
design/stage_pkg.sv
design/message_pkg.sv
design/root_compare_tree.sv
design/message_buffer.sv
design/cluster_state.sv
design/direct_message_router.sv
design/processing_unit.sv
test/processing_unit_tb.sv

// File: test/processing_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "decoder_settings.svh"

module processing_unit_tb;

    localparam message_pkg::address_t own_address = {5'd1, 5'd2, 5'd0};  // k=1 i=2 j=0
    localparam int timeout_cycles = 20;

    // one spread-stage step
    typedef struct packed {
        message_pkg::neighbor_mask_t grown;        // fully grown neighbors
        message_pkg::address_t       base;         // lowest candidate root of the row
        message_pkg::direct_mask_t   local_valid;  // inputs addressed to this site
        message_pkg::direct_mask_t   odd;
        message_pkg::direct_mask_t   touch;
        message_pkg::direct_mask_t   channel;      // expected one-hot output channel
    } row_t;

    logic clk;
    logic reset;
    logic init_is_error_syndrome;
    stage_pkg::stage_t stage_in;
    message_pkg::neighbor_mask_t neighbor_is_fully_grown;
    message_pkg::neighbor_mask_t neighbor_is_odd_cluster;
    message_pkg::address_t neighbor_roots [`NEIGHBOR_COUNT];
    logic neighbor_increase;
    message_pkg::direct_msg_t direct_out_data;
    message_pkg::direct_mask_t direct_out_valid;
    message_pkg::direct_mask_t direct_out_is_full;
    message_pkg::direct_msg_t direct_in_data [`DIRECT_CHANNEL_COUNT];
    message_pkg::direct_mask_t direct_in_valid;
    message_pkg::direct_mask_t direct_in_is_taken;
    message_pkg::address_t old_root;
    message_pkg::address_t updated_root;
    logic is_error_syndrome;
    logic is_odd_cluster;
    logic is_touching_boundary;
    logic is_odd_cardinality;
    logic is_processing;

    row_t rows [5];
    message_pkg::address_t exp_root;  // reference model of the site
    logic exp_card;
    logic exp_touch;
    logic exp_syndrome;
    int pulses;

    processing_unit #(.k(1), .i(2), .j(0)) u_dut (
        .clk                     (clk),
        .reset                   (reset),
        .init_is_error_syndrome  (init_is_error_syndrome),
        .stage_in                (stage_in),
        .neighbor_is_fully_grown (neighbor_is_fully_grown),
        .neighbor_is_odd_cluster (neighbor_is_odd_cluster),
        .neighbor_roots          (neighbor_roots),
        .neighbor_increase       (neighbor_increase),
        .direct_out_data         (direct_out_data),
        .direct_out_valid        (direct_out_valid),
        .direct_out_is_full      (direct_out_is_full),
        .direct_in_data          (direct_in_data),
        .direct_in_valid         (direct_in_valid),
        .direct_in_is_taken      (direct_in_is_taken),
        .old_root                (old_root),
        .updated_root            (updated_root),
        .is_error_syndrome       (is_error_syndrome),
        .is_odd_cluster          (is_odd_cluster),
        .is_touching_boundary    (is_touching_boundary),
        .is_odd_cardinality      (is_odd_cardinality),
        .is_processing           (is_processing)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $fatal(1, "timeout");
    endtask

    // drive a stage and count grow pulses seen at each falling edge
    task automatic hold_stage(input stage_pkg::stage_t s, input int cycles, output int count);
        count = 0;
        stage_in = s;
        repeat (cycles) begin
            @(negedge clk);
            if (neighbor_increase) count++;
        end
    endtask

    task automatic wait_for_change(input message_pkg::direct_mask_t from, input string what);
        int n;
        n = 0;
        while (direct_out_valid == from) begin
            if (n == timeout_cycles) timed_out(what);
            @(negedge clk);
            n++;
        end
    endtask

    task automatic expect_message(input message_pkg::address_t root, input logic card,
                                  input logic touch, input message_pkg::direct_mask_t channel);
        message_pkg::direct_msg_t msg;
        msg = {root, card, touch};
        wait_for_change('0, "an outgoing direct message");
        check_value("direct_out_valid", 32'(direct_out_valid), 32'(channel));
        check_value("direct_out_data", 32'(direct_out_data), 32'(msg));
        wait_for_change(channel, "the outgoing message to be taken");
        check_value("direct_out_valid", 32'(direct_out_valid), 32'h0);
    endtask

    task automatic load_syndrome();
        int count;
        init_is_error_syndrome = 1'b1;
        hold_stage(stage_pkg::STAGE_MEASUREMENT_LOADING, 2, count);
        hold_stage(stage_pkg::STAGE_IDLE, 2, count);  // registered stage still loads once more
        init_is_error_syndrome = 1'b0;
        exp_root = own_address;
        exp_card = 1'b1;
        exp_touch = 1'b0;
        exp_syndrome = 1'b1;
        check_value("is_error_syndrome", 32'(is_error_syndrome), 32'h1);
        check_value("is_odd_cluster", 32'(is_odd_cluster), 32'h1);
        check_value("is_odd_cardinality", 32'(is_odd_cardinality), 32'h1);
        check_value("updated_root", 32'(updated_root), 32'(own_address));
    endtask

    task automatic apply_row(input row_t r);
        message_pkg::address_t min_root;
        logic changed;
        logic new_touch;
        logic tell_card;
        logic tell_bound;
        neighbor_is_fully_grown = r.grown;
        for (int n = 0; n < `NEIGHBOR_COUNT; n++) begin
            if (r.grown[n])
                neighbor_roots[n] = message_pkg::address_t'(15'(r.base) + 15'($urandom % 4));
            else
                neighbor_roots[n] = message_pkg::address_t'(15'($urandom));  // must never win
        end
        for (int c = 0; c < `DIRECT_CHANNEL_COUNT; c++) begin
            direct_in_data[c] = {own_address, r.odd[c], r.touch[c]};
        end
        direct_in_valid = r.local_valid;
        min_root = exp_root;
        for (int n = 0; n < `NEIGHBOR_COUNT; n++) begin
            if (r.grown[n] && neighbor_roots[n] < min_root) min_root = neighbor_roots[n];
        end
        changed = min_root != exp_root;
        new_touch = exp_touch | (|(r.local_valid & r.touch));
        tell_card = changed && exp_syndrome;
        tell_bound = (changed && new_touch) || (new_touch != exp_touch);
        #1;
        check_value("direct_in_is_taken", 32'(direct_in_is_taken), 32'(r.local_valid));
        @(negedge clk);
        direct_in_valid = '0;
        exp_card = exp_card ^ (^(r.local_valid & r.odd));
        exp_root = min_root;
        exp_touch = new_touch;
        check_value("updated_root", 32'(updated_root), 32'(exp_root));
        check_value("is_odd_cardinality", 32'(is_odd_cardinality), 32'(exp_card));
        check_value("is_touching_boundary", 32'(is_touching_boundary), 32'(exp_touch));
        if ((tell_card || tell_bound) && min_root != own_address) begin
            expect_message(min_root, tell_card, tell_bound, r.channel);
        end else begin
            repeat (4) begin
                @(negedge clk);
                check_value("direct_out_valid", 32'(direct_out_valid), 32'h0);
            end
        end
    endtask

    // foreign message stalls on a full channel while an own message waits behind it
    task automatic forward_under_backpressure();
        message_pkg::direct_msg_t foreign;
        message_pkg::direct_msg_t second;
        message_pkg::direct_msg_t own;
        foreign = {{5'd1, 5'd2, 5'd5}, 1'b1, 1'b0};  // same k and i, leaves on channel 2
        second = {{5'd1, 5'd2, 5'd7}, 1'b0, 1'b1};
        neighbor_is_fully_grown = 6'b000001;
        neighbor_roots[0] = {5'd0, 5'd0, 5'd1};    // root change queues an own message
        direct_out_is_full = 3'b100;
        exp_root = {5'd0, 5'd0, 5'd1};
        own = {exp_root, exp_syndrome, exp_touch};
        @(negedge clk);
        check_value("updated_root", 32'(updated_root), 32'(exp_root));
        direct_in_data[1] = foreign;  // arrives while the own message is pending
        direct_in_valid = 3'b010;
        #1;
        check_value("direct_in_is_taken", 32'(direct_in_is_taken), 32'h2);
        @(negedge clk);
        direct_in_data[0] = second;
        direct_in_valid = 3'b001;
        wait_for_change('0, "the forwarded message");
        repeat (4) begin
            check_value("direct_out_valid", 32'(direct_out_valid), 32'h4);
            check_value("direct_out_data", 32'(direct_out_data), 32'(foreign));
            check_value("direct_in_is_taken", 32'(direct_in_is_taken), 32'h0);
            check_value("is_processing", 32'(is_processing), 32'h1);
            @(negedge clk);
        end
        direct_in_valid = '0;
        direct_out_is_full = '0;  // release the channel
        wait_for_change(3'b100, "the forwarded message to leave");
        check_value("direct_out_valid", 32'(direct_out_valid), 32'h1);
        check_value("direct_out_data", 32'(direct_out_data), 32'(own));
        wait_for_change(3'b001, "the own message to leave");
    endtask

    initial begin
        void'($urandom(36782));
        clk = 1'b0;
        reset = 1'b1;
        init_is_error_syndrome = 1'b0;
        stage_in = stage_pkg::STAGE_IDLE;
        neighbor_is_fully_grown = '0;
        neighbor_is_odd_cluster = '0;
        direct_out_is_full = '0;
        direct_in_valid = '0;
        for (int n = 0; n < `NEIGHBOR_COUNT; n++) neighbor_roots[n] = '0;
        for (int c = 0; c < `DIRECT_CHANNEL_COUNT; c++) direct_in_data[c] = '0;
        rows[0] = '{6'b000101, {5'd1, 5'd1, 5'd8}, 3'b000, 3'b000, 3'b000, 3'b010};
        rows[1] = '{6'b110000, {5'd1, 5'd0, 5'd3}, 3'b000, 3'b000, 3'b000, 3'b010};
        rows[2] = '{6'b001010, {5'd0, 5'd7, 5'd9}, 3'b000, 3'b000, 3'b000, 3'b001};
        rows[3] = '{6'b000000, {5'd0, 5'd0, 5'd0}, 3'b011, 3'b001, 3'b000, 3'b001};
        rows[4] = '{6'b000000, {5'd0, 5'd0, 5'd0}, 3'b111, 3'b100, 3'b010, 3'b001};
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("direct_out_valid", 32'(direct_out_valid), 32'h0);
        check_value("direct_in_is_taken", 32'(direct_in_is_taken), 32'h0);
        check_value("neighbor_increase", 32'(neighbor_increase), 32'h0);
        check_value("is_processing", 32'(is_processing), 32'h0);
        check_value("old_root", 32'(old_root), 32'(own_address));
        check_value("updated_root", 32'(updated_root), 32'(own_address));
        load_syndrome();
        hold_stage(stage_pkg::STAGE_SPREAD_CLUSTER, 2, pulses);  // stage reg catches up
        foreach (rows[r]) apply_row(rows[r]);
        forward_under_backpressure();
        neighbor_is_fully_grown = '0;
        load_syndrome();
        hold_stage(stage_pkg::STAGE_SPREAD_CLUSTER, 2, pulses);
        hold_stage(stage_pkg::STAGE_SYNC_IS_ODD_CLUSTER, 3, pulses);
        check_value("is_odd_cluster", 32'(is_odd_cluster), 32'h1);
        hold_stage(stage_pkg::STAGE_GROW_BOUNDARY, 4, pulses);
        check_value("neighbor_increase pulses", 32'(pulses), 32'h1);
        hold_stage(stage_pkg::STAGE_SYNC_IS_ODD_CLUSTER, 2, pulses);
        hold_stage(stage_pkg::STAGE_GROW_BOUNDARY, 4, pulses);
        check_value("neighbor_increase pulses", 32'(pulses), 32'h1);
        hold_stage(stage_pkg::STAGE_SPREAD_CLUSTER, 2, pulses);  // z edge reached, j is 0
        check_value("is_touching_boundary", 32'(is_touching_boundary), 32'h1);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
